// File: compile.f
+incdir+.
dma_pkg.sv
dma_transfer_id_gen.sv
dma_rsp_spill.sv
dma_req_fifo.sv
dma_nd_midend.sv
dma_inst_decoder.sv
dma_frontend_top.sv
tb_dma_frontend.sv

// File: dma_consts.svh
// ----------------------------------------------------------------------
// Widths, depths and instruction encoding of the single-channel DMA
// frontend. FIFO depth and burst limit must be powers of two.
// ----------------------------------------------------------------------
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

`define DMA_ADDR_WIDTH       48
`define DMA_DATA_WIDTH       64
`define DMA_ID_WIDTH         32
`define DMA_REP_WIDTH        32
`define DMA_ACC_ID_WIDTH     5
`define DMA_FIFO_DEPTH       4
`define DMA_BURSTS_IN_FLIGHT 4

// field positions in the instruction word
`define DMA_OP_MSB  27
`define DMA_OP_LSB  25
`define DMA_CFG_MSB 21
`define DMA_CFG_LSB 20

// op codes
`define DMA_OP_DMSRC   3'd0
`define DMA_OP_DMDST   3'd1
`define DMA_OP_DMCPYI  3'd2
`define DMA_OP_DMCPY   3'd3
`define DMA_OP_DMSTATI 3'd4
`define DMA_OP_DMSTAT  3'd5
`define DMA_OP_DMSTR   3'd6
`define DMA_OP_DMREP   3'd7

`endif

// File: dma_frontend_top.sv
// ----------------------------------------------------------------------
// Single-channel DMA frontend. The backend sits outside: it takes the
// burst stream and returns one done pulse per burst, in order.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module dma_frontend_top
    import dma_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  acc_req_t   acc_req_i,
    input  logic       acc_req_valid_i,
    output logic       acc_req_ready_o,
    output acc_rsp_t   acc_rsp_o,
    output logic       acc_rsp_valid_o,
    input  logic       acc_rsp_ready_i,
    output burst_req_t burst_req_o,
    output logic       burst_valid_o,
    input  logic       burst_ready_i,
    input  logic       burst_done_i,
    output logic       busy_o
);

    nd_req_t  fe_req;
    logic     fe_valid;
    logic     fe_ready;
    nd_req_t  mid_req;
    logic     mid_valid;
    logic     mid_ready;
    logic     fifo_empty;
    logic     mid_busy;
    logic     issue;
    logic     retire;
    tf_id_t   next_id;
    tf_id_t   completed_id;
    acc_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;

    assign busy_o = ~fifo_empty | mid_busy;

    dma_inst_decoder i_dma_inst_decoder (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_i       ( acc_req_i       ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_ready_o ( acc_req_ready_o ),
        .nd_req_o        ( fe_req          ),
        .nd_valid_o      ( fe_valid        ),
        .nd_ready_i      ( fe_ready        ),
        .issue_o         ( issue           ),
        .next_id_i       ( next_id         ),
        .completed_id_i  ( completed_id    ),
        .busy_i          ( busy_o          ),
        .rsp_o           ( rsp             ),
        .rsp_valid_o     ( rsp_valid       ),
        .rsp_ready_i     ( rsp_ready       )
    );

    dma_req_fifo i_dma_req_fifo (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .data_i  ( fe_req     ),
        .valid_i ( fe_valid   ),
        .ready_o ( fe_ready   ),
        .data_o  ( mid_req    ),
        .valid_o ( mid_valid  ),
        .ready_i ( mid_ready  ),
        .empty_o ( fifo_empty )
    );

    dma_nd_midend i_dma_nd_midend (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .nd_req_i      ( mid_req       ),
        .nd_valid_i    ( mid_valid     ),
        .nd_ready_o    ( mid_ready     ),
        .burst_o       ( burst_req_o   ),
        .burst_valid_o ( burst_valid_o ),
        .burst_ready_i ( burst_ready_i ),
        .burst_done_i  ( burst_done_i  ),
        .retire_o      ( retire        ),
        .busy_o        ( mid_busy      )
    );

    dma_transfer_id_gen i_dma_transfer_id_gen (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .issue_i        ( issue        ),
        .retire_i       ( retire       ),
        .next_id_o      ( next_id      ),
        .completed_id_o ( completed_id )
    );

    dma_rsp_spill i_dma_rsp_spill (
        .clk_i   ( clk_i           ),
        .rst_n_i ( rst_n_i         ),
        .data_i  ( rsp             ),
        .valid_i ( rsp_valid       ),
        .ready_o ( rsp_ready       ),
        .data_o  ( acc_rsp_o       ),
        .valid_o ( acc_rsp_valid_o ),
        .ready_i ( acc_rsp_ready_i )
    );

endmodule

// File: dma_inst_decoder.sv
// ----------------------------------------------------------------------
// Accelerator instruction decoder. Setup ops are taken at once with no
// response. Copies need both the response path and the job FIFO ready,
// status reads only the response path.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_inst_decoder
    import dma_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    // accelerator request
    input  acc_req_t acc_req_i,
    input  logic     acc_req_valid_i,
    output logic     acc_req_ready_o,
    // job stream into the FIFO
    output nd_req_t  nd_req_o,
    output logic     nd_valid_o,
    input  logic     nd_ready_i,
    output logic     issue_o,
    // status inputs
    input  tf_id_t   next_id_i,
    input  tf_id_t   completed_id_i,
    input  logic     busy_i,
    // response into the spill
    output acc_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i
);

    nd_req_t job_q;
    nd_req_t job_d;
    op_t     op;
    cfg_t    sel;

    assign op = acc_req_i.data_op[`DMA_OP_MSB:`DMA_OP_LSB];

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    always_comb begin
        job_d           = job_q;
        sel             = '0;
        acc_req_ready_o = 1'b0;
        nd_valid_o      = 1'b0;
        rsp_valid_o     = 1'b0;
        rsp_o.id        = acc_req_i.id;
        rsp_o.data      = '0;
        rsp_o.error     = 1'b0;

        if (acc_req_valid_i) begin
            case (op)
                `DMA_OP_DMSRC: begin
                    job_d.burst.src_addr = {acc_req_i.data_argb[`DMA_ADDR_WIDTH-33:0],
                                            acc_req_i.data_arga[31:0]};
                    acc_req_ready_o      = 1'b1;
                end
                `DMA_OP_DMDST: begin
                    job_d.burst.dst_addr = {acc_req_i.data_argb[`DMA_ADDR_WIDTH-33:0],
                                            acc_req_i.data_arga[31:0]};
                    acc_req_ready_o      = 1'b1;
                end
                `DMA_OP_DMSTR: begin
                    job_d.src_stride = stride_t'(acc_req_i.data_arga);
                    job_d.dst_stride = stride_t'(acc_req_i.data_argb);
                    acc_req_ready_o  = 1'b1;
                end
                `DMA_OP_DMREP: begin
                    job_d.reps      = reps_t'(acc_req_i.data_arga);
                    acc_req_ready_o = 1'b1;
                end
                `DMA_OP_DMCPYI, `DMA_OP_DMCPY: begin
                    if (op == `DMA_OP_DMCPYI) begin
                        sel = acc_req_i.data_op[`DMA_CFG_MSB:`DMA_CFG_LSB];
                    end else begin
                        sel = acc_req_i.data_argb[1:0];
                    end
                    // only offer the job once its response has a slot
                    nd_valid_o = rsp_ready_i;
                    if (rsp_ready_i && nd_ready_i) begin
                        rsp_o.data      = data_t'(next_id_i);
                        rsp_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                default: begin
                    // DMSTAT and DMSTATI
                    if (op == `DMA_OP_DMSTATI) begin
                        sel = acc_req_i.data_op[`DMA_CFG_MSB:`DMA_CFG_LSB];
                    end else begin
                        sel = acc_req_i.data_argb[1:0];
                    end
                    case (sel)
                        2'd0:    rsp_o.data = data_t'(completed_id_i);
                        2'd1:    rsp_o.data = data_t'(next_id_i);
                        2'd2:    rsp_o.data = data_t'(busy_i);
                        default: rsp_o.data = data_t'(!nd_ready_i);
                    endcase
                    rsp_valid_o     = rsp_ready_i;
                    acc_req_ready_o = rsp_ready_i;
                end
            endcase
        end
    end

    // job as pushed; 1D copies ignore the programmed reps
    always_comb begin
        nd_req_o              = job_q;
        nd_req_o.burst.length = addr_t'(acc_req_i.data_arga);
        if (!sel[1]) begin
            nd_req_o.reps = reps_t'(1);
        end
    end

    assign issue_o = nd_valid_o & nd_ready_i;

    // setup registers persist across jobs
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            job_q <= '0;
        end else begin
            job_q <= job_d;
        end
    end

endmodule

// File: dma_nd_midend.sv
// ----------------------------------------------------------------------
// 2D midend. Splits a job into reps bursts (0 counts as 1) with strides
// added unsigned. Dones must come in issue order, one per burst.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_nd_midend
    import dma_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  nd_req_t    nd_req_i,
    input  logic       nd_valid_i,
    output logic       nd_ready_o,
    output burst_req_t burst_o,
    output logic       burst_valid_o,
    input  logic       burst_ready_i,
    input  logic       burst_done_i,
    output logic       retire_o,
    output logic       busy_o
);

    localparam int unsigned QPtrWidth = $clog2(`DMA_BURSTS_IN_FLIGHT);

    midend_state_e                   state_q;
    burst_req_t                      cur_q;
    stride_t                         src_stride_q;
    stride_t                         dst_stride_q;
    reps_t                           reps_left_q;
    // last-burst flags of outstanding bursts, oldest at rd_ptr_q
    logic [`DMA_BURSTS_IN_FLIGHT-1:0] last_q;
    logic [QPtrWidth-1:0]            wr_ptr_q;
    logic [QPtrWidth-1:0]            rd_ptr_q;
    logic [QPtrWidth:0]              out_cnt_q;
    logic                            retire_q;
    logic                            take_job;
    logic                            burst_hs;
    logic                            is_last;

    assign nd_ready_o    = (state_q == IDLE);
    assign take_job      = nd_valid_i & nd_ready_o;
    assign burst_o       = cur_q;
    assign burst_valid_o = (state_q == ISSUE) &&
                           (out_cnt_q != (QPtrWidth+1)'(`DMA_BURSTS_IN_FLIGHT));
    assign burst_hs      = burst_valid_o & burst_ready_i;
    assign is_last       = (reps_left_q == reps_t'(1));
    assign retire_o      = retire_q;
    assign busy_o        = (state_q == ISSUE) | (out_cnt_q != '0) | retire_q;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            out_cnt_q <= '0;
            retire_q  <= 1'b0;
        end else begin
            retire_q <= burst_done_i & last_q[rd_ptr_q];
            case (state_q)
                IDLE:    if (take_job) state_q <= ISSUE;
                ISSUE:   if (burst_hs && is_last) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
            if (burst_hs) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (burst_done_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (burst_hs && !burst_done_i) begin
                out_cnt_q <= out_cnt_q + 1'b1;
            end else if (burst_done_i && !burst_hs) begin
                out_cnt_q <= out_cnt_q - 1'b1;
            end
        end
    end

    // current burst and remaining repetitions
    always_ff @(posedge clk_i) begin
        if (take_job) begin
            cur_q        <= nd_req_i.burst;
            src_stride_q <= nd_req_i.src_stride;
            dst_stride_q <= nd_req_i.dst_stride;
            reps_left_q  <= (nd_req_i.reps == '0) ? reps_t'(1) : nd_req_i.reps;
        end else if (burst_hs) begin
            cur_q.src_addr <= cur_q.src_addr + addr_t'(src_stride_q);
            cur_q.dst_addr <= cur_q.dst_addr + addr_t'(dst_stride_q);
            reps_left_q    <= reps_left_q - reps_t'(1);
        end
        if (burst_hs) begin
            last_q[wr_ptr_q] <= is_last;
        end
    end

endmodule

// File: dma_pkg.sv
// ----------------------------------------------------------------------
// Shared types of the DMA frontend. Widths come from the consts header.
// ----------------------------------------------------------------------
`include "dma_consts.svh"

package dma_pkg;

    typedef logic [`DMA_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0]   data_t;
    typedef logic [`DMA_ID_WIDTH-1:0]     tf_id_t;
    typedef logic [`DMA_REP_WIDTH-1:0]    reps_t;
    typedef logic [`DMA_REP_WIDTH-1:0]    stride_t;
    typedef logic [`DMA_ACC_ID_WIDTH-1:0] acc_id_t;
    // op code and two-bit config/status selector
    typedef logic [`DMA_OP_MSB-`DMA_OP_LSB:0]   op_t;
    typedef logic [`DMA_CFG_MSB-`DMA_CFG_LSB:0] cfg_t;

    // accelerator bus request and response
    typedef struct packed {
        acc_id_t     id;
        logic [31:0] data_op;
        data_t       data_arga;
        data_t       data_argb;
    } acc_req_t;

    typedef struct packed {
        acc_id_t id;
        data_t   data;
        logic    error;
    } acc_rsp_t;

    // ------------------------------------------------------------------
    // job descriptions
    // ------------------------------------------------------------------
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        addr_t length;
    } burst_req_t;

    typedef struct packed {
        burst_req_t burst;
        stride_t    src_stride;
        stride_t    dst_stride;
        reps_t      reps;
    } nd_req_t;

    typedef enum logic {
        IDLE,
        ISSUE
    } midend_state_e;

endpackage

// File: dma_req_fifo.sv
// ----------------------------------------------------------------------
// Job FIFO between decoder and midend. Depth must be a power of two;
// a pushed job shows at the output on the following cycle.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_req_fifo
    import dma_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  nd_req_t data_i,
    input  logic    valid_i,
    output logic    ready_o,
    output nd_req_t data_o,
    output logic    valid_o,
    input  logic    ready_i,
    output logic    empty_o
);

    localparam int unsigned PtrWidth = $clog2(`DMA_FIFO_DEPTH);

    nd_req_t             mem_q [`DMA_FIFO_DEPTH];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [PtrWidth:0]   count_q;
    logic                push;
    logic                pop;

    assign ready_o = (count_q != (PtrWidth+1)'(`DMA_FIFO_DEPTH));
    assign valid_o = (count_q != '0);
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: dma_rsp_spill.sv
// ----------------------------------------------------------------------
// Two-slot spill register on the response path. ready_o depends only
// on slot state, never on ready_i. Order is kept: B holds the older.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module dma_rsp_spill
    import dma_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  acc_rsp_t data_i,
    input  logic     valid_i,
    output logic     ready_o,
    output acc_rsp_t data_o,
    output logic     valid_o,
    input  logic     ready_i
);

    acc_rsp_t a_data_q;
    acc_rsp_t b_data_q;
    logic     a_full_q;
    logic     b_full_q;
    logic     a_fill;
    logic     a_drain;
    logic     b_fill;
    logic     b_drain;

    assign ready_o = ~a_full_q | ~b_full_q;
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // A empties whenever B is free, either out or into B
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            a_full_q <= a_fill | (a_full_q & ~a_drain);
            b_full_q <= b_fill | (b_full_q & ~b_drain);
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= data_i;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

endmodule

// File: dma_transfer_id_gen.sv
// ----------------------------------------------------------------------
// Transfer ID counters. Both wrap silently at the ID width.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module dma_transfer_id_gen
    import dma_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   issue_i,
    input  logic   retire_i,
    output tf_id_t next_id_o,
    output tf_id_t completed_id_o
);

    tf_id_t next_q;
    tf_id_t completed_q;

    // first job gets ID 1, so 0 means nothing done yet
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_q      <= tf_id_t'(1);
            completed_q <= '0;
        end else begin
            if (issue_i) begin
                next_q <= next_q + tf_id_t'(1);
            end
            if (retire_i) begin
                completed_q <= completed_q + tf_id_t'(1);
            end
        end
    end

    assign next_id_o      = next_q;
    assign completed_id_o = completed_q;

endmodule

// File: tb_dma_frontend.sv
// ----------------------------------------------------------------------
// Self-checking testbench for the DMA frontend. The testbench plays the
// backend: random burst ready, in-order done pulses after random delay.
// Inputs change on the falling edge, outputs are sampled 10 ns later.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_consts.svh"

module tb_dma_frontend
    import dma_pkg::*;
;

    localparam int Timeout = 2000;

    logic       clk_i;
    logic       rst_n_i;
    acc_req_t   acc_req_i;
    logic       acc_req_valid_i;
    logic       acc_req_ready_o;
    acc_rsp_t   acc_rsp_o;
    logic       acc_rsp_valid_o;
    logic       acc_rsp_ready_i;
    burst_req_t burst_req_o;
    logic       burst_valid_o;
    logic       burst_ready_i;
    logic       burst_done_i;
    logic       busy_o;

    // expected streams, in order
    burst_req_t exp_bursts[$];
    acc_rsp_t   exp_rsps[$];

    integer  seed = 60871;
    int      errors = 0;
    int      outstanding = 0;
    int      copies = 0;
    int      pass_cnt = 0;
    int      fail_cnt = 0;
    int      errors_at_start;
    string   test_name = "reset";
    logic    hold_ready = 1'b0;
    acc_id_t req_tag = '0;

    // shadow of the decoder job registers
    addr_t   sh_src = '0;
    addr_t   sh_dst = '0;
    stride_t sh_sstr = '0;
    stride_t sh_dstr = '0;
    reps_t   sh_reps = '0;

    dma_frontend_top dut_i (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_i       ( acc_req_i       ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_ready_o ( acc_req_ready_o ),
        .acc_rsp_o       ( acc_rsp_o       ),
        .acc_rsp_valid_o ( acc_rsp_valid_o ),
        .acc_rsp_ready_i ( acc_rsp_ready_i ),
        .burst_req_o     ( burst_req_o     ),
        .burst_valid_o   ( burst_valid_o   ),
        .burst_ready_i   ( burst_ready_i   ),
        .burst_done_i    ( burst_done_i    ),
        .busy_o          ( busy_o          )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // bursts per job: 1D copies give one, and reps 0 acts as 1
    function automatic int unsigned ref_reps(input reps_t reps, input bit two_d);
        if (!two_d || reps == '0) begin
            return 1;
        end
        return reps;
    endfunction

    function automatic burst_req_t ref_burst(input addr_t src, input addr_t dst,
                                             input addr_t len, input stride_t s_str,
                                             input stride_t d_str, input int unsigned idx);
        burst_req_t b;
        b.src_addr = src + addr_t'(s_str) * addr_t'(idx);
        b.dst_addr = dst + addr_t'(d_str) * addr_t'(idx);
        b.length   = len;
        return b;
    endfunction

    function automatic logic [31:0] make_op(input op_t op, input cfg_t cfg);
        logic [31:0] word;
        word = '0;
        word[`DMA_OP_MSB:`DMA_OP_LSB]   = op;
        word[`DMA_CFG_MSB:`DMA_CFG_LSB] = cfg;
        return word;
    endfunction

    // ------------------------------------------------------------------
    // backend model and compare process
    // ------------------------------------------------------------------
    initial begin : backend_model
        logic [31:0] rnd;
        forever begin
            @(negedge clk_i);
            rnd           = $random(seed);
            burst_done_i  = 1'b0;
            burst_ready_i = rst_n_i && !hold_ready && rnd[0];
            if (rst_n_i && outstanding > 0 && rnd[2:1] == 2'd0) begin
                burst_done_i = 1'b1;
                outstanding--;
            end
        end
    end

    initial begin : compare_outputs
        burst_req_t exp_b;
        acc_rsp_t   exp_r;
        forever begin
            @(negedge clk_i);
            #10;
            if (rst_n_i && burst_valid_o && burst_ready_i) begin
                outstanding++;
                if (exp_bursts.size() == 0) begin
                    $display("test %s: burst %h issued with none expected",
                             test_name, burst_req_o);
                    errors++;
                end else begin
                    exp_b = exp_bursts.pop_front();
                    if (burst_req_o !== exp_b) begin
                        $display("error test %s burst: expected %h actual %h",
                                 test_name, exp_b, burst_req_o);
                        errors++;
                    end
                end
            end
            if (rst_n_i && acc_rsp_valid_o && acc_rsp_ready_i) begin
                if (exp_rsps.size() == 0) begin
                    $display("test %s: response %h arrived with none expected",
                             test_name, acc_rsp_o);
                    errors++;
                end else begin
                    exp_r = exp_rsps.pop_front();
                    if (acc_rsp_o !== exp_r) begin
                        $display("error test %s response: expected %h actual %h",
                                 test_name, exp_r, acc_rsp_o);
                        errors++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // host side tasks
    // ------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("test %s: %s", test_name, msg);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic send_req(input op_t op, input cfg_t imm, input data_t arga,
                            input data_t argb);
        acc_req_t req;
        int       waited;
        req.id        = req_tag;
        req.data_op   = make_op(op, imm);
        req.data_arga = arga;
        req.data_argb = argb;
        @(negedge clk_i);
        acc_req_i       = req;
        acc_req_valid_i = 1'b1;
        #10;
        waited = 0;
        while (!acc_req_ready_o && waited < Timeout) begin
            @(negedge clk_i);
            #10;
            waited++;
        end
        if (!acc_req_ready_o) begin
            abort_run("request was never accepted");
        end
        @(negedge clk_i);
        acc_req_valid_i = 1'b0;
        req_tag++;
    endtask

    task automatic expect_rsp(input data_t data);
        acc_rsp_t r;
        r.id    = req_tag;
        r.data  = data;
        r.error = 1'b0;
        exp_rsps.push_back(r);
    endtask

    // busy_o is driven from registers only, so it is stable here
    task automatic check_busy(input logic expected);
        if (busy_o !== expected) begin
            $display("error test %s busy: expected %b actual %b",
                     test_name, expected, busy_o);
            errors++;
        end
    endtask

    // upper argument bits carry junk the decoder must ignore
    task automatic set_src(input addr_t a);
        sh_src = a;
        send_req(`DMA_OP_DMSRC, 2'd0, {32'hdead_beef, a[31:0]}, {48'hfeed, a[47:32]});
    endtask

    task automatic set_dst(input addr_t a);
        sh_dst = a;
        send_req(`DMA_OP_DMDST, 2'd0, {32'hdead_beef, a[31:0]}, {48'hfeed, a[47:32]});
    endtask

    task automatic set_strides(input stride_t s, input stride_t d);
        sh_sstr = s;
        sh_dstr = d;
        send_req(`DMA_OP_DMSTR, 2'd0, data_t'(s), data_t'(d));
    endtask

    task automatic set_reps(input reps_t r);
        sh_reps = r;
        send_req(`DMA_OP_DMREP, 2'd0, data_t'(r), '0);
    endtask

    // the unused cfg source holds the opposite value
    task automatic copy_job(input bit imm_form, input addr_t len, input bit two_d);
        cfg_t        cfg;
        int unsigned n;
        cfg = two_d ? 2'b10 : 2'b00;
        n   = ref_reps(sh_reps, two_d);
        for (int unsigned i = 0; i < n; i++) begin
            exp_bursts.push_back(ref_burst(sh_src, sh_dst, len, sh_sstr, sh_dstr, i));
        end
        expect_rsp(data_t'(copies + 1));
        copies++;
        if (imm_form) begin
            send_req(`DMA_OP_DMCPYI, cfg, data_t'(len), data_t'(~cfg));
        end else begin
            send_req(`DMA_OP_DMCPY, ~cfg, data_t'(len), data_t'(cfg));
        end
    endtask

    task automatic status_read(input bit imm_form, input cfg_t sel, input data_t expected);
        expect_rsp(expected);
        if (imm_form) begin
            send_req(`DMA_OP_DMSTATI, sel, '0, data_t'(~sel));
        end else begin
            send_req(`DMA_OP_DMSTAT, ~sel, '0, data_t'(sel));
        end
    endtask

    // all bursts done and the last retire counted
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk_i);
        #10;
        while (!(exp_bursts.size() == 0 && outstanding == 0 && !busy_o) &&
               waited < Timeout) begin
            @(negedge clk_i);
            #10;
            waited++;
        end
        if (waited >= Timeout) begin
            abort_run("bursts did not drain in time");
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (exp_rsps.size() != 0 && waited < Timeout) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_rsps.size() != 0) begin
            abort_run("expected responses never arrived");
        end
        if (errors == errors_at_start) begin
            $display("test %s: pass", test_name);
            pass_cnt++;
        end else begin
            $display("test %s: FAIL with %0d errors", test_name, errors - errors_at_start);
            fail_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n_i         = 1'b0;
        acc_req_i       = '0;
        acc_req_valid_i = 1'b0;
        acc_rsp_ready_i = 1'b1;
        burst_ready_i   = 1'b0;
        burst_done_i    = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;

        start_test("copy_1d");
        set_src(48'h0012_3456_7000);
        set_dst(48'h0000_abcd_0800);
        copy_job(1'b1, 48'h200, 1'b0);
        wait_drain();
        finish_test();

        start_test("copy_2d");
        set_strides(32'h100, 32'h40);
        set_reps(32'd3);
        copy_job(1'b0, 48'h20, 1'b1);
        copy_job(1'b1, 48'h30, 1'b0);
        wait_drain();
        finish_test();

        start_test("status");
        status_read(1'b0, 2'd0, data_t'(copies));
        status_read(1'b1, 2'd1, data_t'(copies + 1));
        finish_test();

        start_test("fifo_full");
        hold_ready = 1'b1;
        for (int i = 0; i < `DMA_FIFO_DEPTH + 1; i++) begin
            copy_job(i[0], addr_t'(32 + i * 8), 1'b0);
        end
        status_read(1'b1, 2'd3, data_t'(1));
        status_read(1'b0, 2'd2, data_t'(1));
        check_busy(1'b1);
        hold_ready = 1'b0;
        wait_drain();
        status_read(1'b0, 2'd2, data_t'(0));
        finish_test();

        start_test("rsp_stall");
        @(negedge clk_i);
        acc_rsp_ready_i = 1'b0;
        status_read(1'b1, 2'd1, data_t'(copies + 1));
        copy_job(1'b1, 48'h40, 1'b0);
        fork
            status_read(1'b0, 2'd1, data_t'(copies + 1));
            begin
                repeat (6) begin
                    @(negedge clk_i);
                    #10;
                    if (acc_req_valid_i && acc_req_ready_o) begin
                        $display("test %s: request taken while both response slots were full",
                                 test_name);
                        errors++;
                    end
                end
                @(negedge clk_i);
                acc_rsp_ready_i = 1'b1;
            end
        join
        wait_drain();
        finish_test();

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
